/* hw/afu_pkg.sv */
// AFU shared definitions
// Opcodes, request word views and the completion word layout used on
// the host streaming port

`default_nettype none

package afu_pkg;

   // Stream word width, fixed by the request and completion formats
   localparam int WORD_W = 64;

   // ---------------------------------------------------------------------
   // Opcodes
   // ---------------------------------------------------------------------
   typedef enum logic [3:0] {
      OP_WR  = 4'd1,
      OP_RD  = 4'd2,
      OP_ADD = 4'd3,
      OP_CPL = 4'd8,
      OP_UR  = 4'd15
   } afu_op_e;

   // ---------------------------------------------------------------------
   // Request word
   // ---------------------------------------------------------------------
   // Posted write and fetch-and-add, data is the addend for OP_ADD
   typedef struct packed {
      logic [3:0]  opcode;
      logic [7:0]  tag;
      logic [7:0]  addr;
      logic [11:0] rsvd;
      logic [31:0] data;
   } req_wr_t;

   // Burst read, count is the number of words minus one
   typedef struct packed {
      logic [3:0]  opcode;
      logic [7:0]  tag;
      logic [7:0]  addr;
      logic [2:0]  count;
      logic [40:0] rsvd;
   } req_rd_t;

   // One request word, viewed by opcode
   typedef union packed {
      req_wr_t wr;
      req_rd_t rd;
   } req_word_u;

   // ---------------------------------------------------------------------
   // Completion word
   // ---------------------------------------------------------------------
   typedef struct packed {
      afu_op_e     opcode;
      logic [7:0]  tag;
      logic [7:0]  addr;
      logic [11:0] rsvd;
      logic [31:0] data;
   } cpl_word_t;

endpackage

`default_nettype wire

/* hw/axis_pipeline.sv */
// Stream register pipeline
// Chain of PL_DEPTH valid/ready skid stages, one cycle each, with
// registered ready and full throughput

`default_nettype none

module axis_pipeline
   import afu_pkg::*;
#(
   parameter int PL_DEPTH = 2
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              s_tvalid,
   output logic              s_tready,
   input  logic [WORD_W-1:0] s_tdata,
   output logic              m_tvalid,
   input  logic              m_tready,
   output logic [WORD_W-1:0] m_tdata
);

   // Index i is the input side of stage i, index PL_DEPTH the output
   logic              pl_valid [PL_DEPTH+1];
   logic              pl_ready [PL_DEPTH+1];
   logic [WORD_W-1:0] pl_data  [PL_DEPTH+1];

   assign pl_valid[0]        = s_tvalid;
   assign pl_data[0]         = s_tdata;
   assign s_tready           = pl_ready[0];

   assign m_tvalid           = pl_valid[PL_DEPTH];
   assign m_tdata            = pl_data[PL_DEPTH];
   assign pl_ready[PL_DEPTH] = m_tready;

   // ---------------------------------------------------------------------
   // Skid stages
   // ---------------------------------------------------------------------
   for (genvar i = 0; i < PL_DEPTH; i++) begin : g_stage
      logic              main_valid;
      logic              skid_valid;
      logic [WORD_W-1:0] main_data;
      logic [WORD_W-1:0] skid_data;
      logic              out_free;
      logic              to_skid;

      // Main register may load when empty or draining
      assign out_free = !main_valid || pl_ready[i+1];
      // Incoming word parks in the skid while the output stalls
      assign to_skid  = !out_free && pl_valid[i] && !skid_valid;

      // Ready comes straight from a flop
      assign pl_ready[i]   = !skid_valid;
      assign pl_valid[i+1] = main_valid;
      assign pl_data[i+1]  = main_data;

      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
         end else if (out_free) begin
            // Skid drains first, input is blocked while it is full
            main_valid <= skid_valid || pl_valid[i];
            skid_valid <= 1'b0;
         end else if (to_skid) begin
            skid_valid <= 1'b1;
         end
      end

      always_ff @(posedge clk) begin
         if (out_free) begin
            main_data <= skid_valid ? skid_data : pl_data[i];
         end
         if (to_skid) begin
            skid_data <= pl_data[i];
         end
      end
   end

endmodule

`default_nettype wire

/* hw/pr_freeze_bridge.sv */
// Freeze bridge for partial reconfiguration
// Gates valid and ready on the RX and TX streams while pr_freeze is high,
// with a register pipeline in each direction

`default_nettype none

module pr_freeze_bridge
   import afu_pkg::*;
#(
   parameter int PL_DEPTH   = 2,
   parameter int FREEZE_DIS = 0
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              pr_freeze,
   // Host RX toward the function
   input  logic              rx_tvalid,
   output logic              rx_tready,
   input  logic [WORD_W-1:0] rx_tdata,
   output logic              req_valid,
   input  logic              req_ready,
   output logic [WORD_W-1:0] req_data,
   // Function TX toward the host
   input  logic              cpl_valid,
   output logic              cpl_ready,
   input  logic [WORD_W-1:0] cpl_data,
   output logic              tx_tvalid,
   input  logic              tx_tready,
   output logic [WORD_W-1:0] tx_tdata
);

   logic              frz;
   logic              rx_gate_valid;
   logic              rx_gate_ready;
   logic              tx_pipe_valid;
   logic              tx_pipe_ready;
   logic [WORD_W-1:0] tx_pipe_data;

   if (FREEZE_DIS == 1) begin : g_frz_off
      assign frz = 1'b0;
   end else begin : g_frz_on
      assign frz = pr_freeze;
   end

   // ---------------------------------------------------------------------
   // RX gate, then pipeline into the function
   // ---------------------------------------------------------------------
   always_comb begin
      rx_gate_valid = rx_tvalid && !frz;
      rx_tready     = rx_gate_ready && !frz;
   end

   axis_pipeline #(.PL_DEPTH(PL_DEPTH)) rx_pipe (
      .clk      (clk),
      .rst_n    (rst_n),
      .s_tvalid (rx_gate_valid),
      .s_tready (rx_gate_ready),
      .s_tdata  (rx_tdata),
      .m_tvalid (req_valid),
      .m_tready (req_ready),
      .m_tdata  (req_data)
   );

   // ---------------------------------------------------------------------
   // Pipeline out of the function, then TX gate
   // ---------------------------------------------------------------------
   axis_pipeline #(.PL_DEPTH(PL_DEPTH)) tx_pipe (
      .clk      (clk),
      .rst_n    (rst_n),
      .s_tvalid (cpl_valid),
      .s_tready (cpl_ready),
      .s_tdata  (cpl_data),
      .m_tvalid (tx_pipe_valid),
      .m_tready (tx_pipe_ready),
      .m_tdata  (tx_pipe_data)
   );

   // Completions stay parked in tx_pipe while frozen
   always_comb begin
      tx_tvalid     = tx_pipe_valid && !frz;
      tx_pipe_ready = tx_tready && !frz;
      tx_tdata      = tx_pipe_data;
   end

endmodule

`default_nettype wire

/* hw/req_decode.sv */
// Request decode
// Takes one request word into a register stage and splits it into
// operation fields, reading the word through the view its opcode selects

`default_nettype none

module req_decode
   import afu_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        req_valid,
   output logic        req_ready,
   input  req_word_u   req_data,
   output logic        op_valid,
   input  logic        op_ready,
   output afu_op_e     op_code,
   output logic [7:0]  op_tag,
   output logic [7:0]  op_addr,
   output logic [31:0] op_data,
   output logic [2:0]  op_count
);

   afu_op_e     d_code;
   logic [7:0]  d_tag;
   logic [7:0]  d_addr;
   logic [31:0] d_data;
   logic [2:0]  d_count;

   // Opcode, tag and address sit in the same bits of both views
   always_comb begin
      d_code = afu_op_e'(req_data.wr.opcode);
      d_tag  = req_data.wr.tag;
      d_addr = req_data.wr.addr;
      if (d_code == OP_RD) begin
         d_data  = '0;
         d_count = req_data.rd.count;
      end else begin
         d_data  = req_data.wr.data;
         d_count = '0;
      end
   end

   // One-entry stage, refills in the cycle it drains
   assign req_ready = !op_valid || op_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         op_valid <= 1'b0;
      end else if (req_ready) begin
         op_valid <= req_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         op_code  <= d_code;
         op_tag   <= d_tag;
         op_addr  <= d_addr;
         op_data  <= d_data;
         op_count <= d_count;
      end
   end

endmodule

`default_nettype wire

/* hw/scratch_execute.sv */
// Scratch memory execute
// Runs posted writes, burst reads and fetch-and-add on a small word array
// and sequences the results of each operation

`default_nettype none

module scratch_execute
   import afu_pkg::*;
#(
   parameter int ADDR_W = 4
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        op_valid,
   output logic        op_ready,
   input  afu_op_e     op_code,
   input  logic [7:0]  op_tag,
   input  logic [7:0]  op_addr,
   input  logic [31:0] op_data,
   input  logic [2:0]  op_count,
   output logic        res_valid,
   input  logic        res_ready,
   output afu_op_e     res_code,
   output logic [7:0]  res_tag,
   output logic [7:0]  res_addr,
   output logic [31:0] res_data
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [31:0]       mem [DEPTH];
   logic [2:0]        rem;
   logic [ADDR_W-1:0] op_idx;
   logic [ADDR_W-1:0] nxt_idx;
   logic              op_take;
   logic              res_take;

   assign op_idx   = op_addr[ADDR_W-1:0];
   // Burst index wraps within the array
   assign nxt_idx  = res_addr[ADDR_W-1:0] + ADDR_W'(1);

   // Next op may enter as the last result leaves
   assign op_ready = !res_valid || (res_ready && rem == 3'd0);
   assign op_take  = op_valid && op_ready;
   assign res_take = res_valid && res_ready;

   // ---------------------------------------------------------------------
   // Scratch array
   // ---------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (op_take) begin
         if (op_code == OP_WR) begin
            mem[op_idx] <= op_data;
         end else if (op_code == OP_ADD) begin
            mem[op_idx] <= mem[op_idx] + op_data;
         end
      end
   end

   // ---------------------------------------------------------------------
   // Result sequencing
   // ---------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         res_valid <= 1'b0;
         rem       <= '0;
      end else if (op_take) begin
         // Writes are posted
         res_valid <= (op_code != OP_WR);
         rem       <= (op_code == OP_RD) ? op_count : 3'd0;
      end else if (res_take) begin
         res_valid <= (rem != 3'd0);
         if (rem != 3'd0) begin
            rem <= rem - 3'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (op_take) begin
         res_tag  <= op_tag;
         res_addr <= op_addr;
         case (op_code)
            OP_WR, OP_RD, OP_ADD: begin
               // Add returns the value before the update
               res_code <= op_code;
               res_data <= mem[op_idx];
            end
            default: begin
               res_code <= OP_UR;
               res_data <= '0;
            end
         endcase
      end else if (res_take && rem != 3'd0) begin
         res_addr <= res_addr + 8'd1;
         res_data <= mem[nxt_idx];
      end
   end

endmodule

`default_nettype wire

/* hw/cpl_result.sv */
// Completion build
// Packs execute results into completion words and holds each word in an
// output register until the TX pipeline takes it

`default_nettype none

module cpl_result
   import afu_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        res_valid,
   output logic        res_ready,
   input  afu_op_e     res_code,
   input  logic [7:0]  res_tag,
   input  logic [7:0]  res_addr,
   input  logic [31:0] res_data,
   output logic        cpl_valid,
   input  logic        cpl_ready,
   output cpl_word_t   cpl_data
);

   // Free when empty or when the held word leaves this cycle
   assign res_ready = !cpl_valid || cpl_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cpl_valid <= 1'b0;
      end else if (res_ready) begin
         cpl_valid <= res_valid;
      end
   end

   // Success codes collapse to OP_CPL
   always_ff @(posedge clk) begin
      if (res_valid && res_ready) begin
         cpl_data.opcode <= (res_code == OP_UR) ? OP_UR : OP_CPL;
         cpl_data.tag    <= res_tag;
         cpl_data.addr   <= res_addr;
         cpl_data.rsvd   <= '0;
         cpl_data.data   <= res_data;
      end
   end

endmodule

`default_nettype wire

/* hw/afu_port_top.sv */
// AFU port top level
// Freeze bridge on the host stream, followed by decode, scratch execute
// and completion build

`default_nettype none

module afu_port_top
   import afu_pkg::*;
#(
   parameter int PL_DEPTH   = 2,
   parameter int FREEZE_DIS = 0,
   parameter int ADDR_W     = 4
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              pr_freeze,
   input  logic              rx_tvalid,
   output logic              rx_tready,
   input  logic [WORD_W-1:0] rx_tdata,
   output logic              tx_tvalid,
   input  logic              tx_tready,
   output logic [WORD_W-1:0] tx_tdata
);

   // Bridge to decode
   logic              req_valid;
   logic              req_ready;
   logic [WORD_W-1:0] req_data;
   // Decode to execute
   logic              op_valid;
   logic              op_ready;
   afu_op_e           op_code;
   logic [7:0]        op_tag;
   logic [7:0]        op_addr;
   logic [31:0]       op_data;
   logic [2:0]        op_count;
   // Execute to completion
   logic              res_valid;
   logic              res_ready;
   afu_op_e           res_code;
   logic [7:0]        res_tag;
   logic [7:0]        res_addr;
   logic [31:0]       res_data;
   // Completion to bridge
   logic              cpl_valid;
   logic              cpl_ready;
   logic [WORD_W-1:0] cpl_data;

   pr_freeze_bridge #(
      .PL_DEPTH   (PL_DEPTH),
      .FREEZE_DIS (FREEZE_DIS)
   ) u_bridge (
      .clk       (clk),
      .rst_n     (rst_n),
      .pr_freeze (pr_freeze),
      .rx_tvalid (rx_tvalid),
      .rx_tready (rx_tready),
      .rx_tdata  (rx_tdata),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_data  (req_data),
      .cpl_valid (cpl_valid),
      .cpl_ready (cpl_ready),
      .cpl_data  (cpl_data),
      .tx_tvalid (tx_tvalid),
      .tx_tready (tx_tready),
      .tx_tdata  (tx_tdata)
   );

   req_decode u_decode (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_data  (req_data),
      .op_valid  (op_valid),
      .op_ready  (op_ready),
      .op_code   (op_code),
      .op_tag    (op_tag),
      .op_addr   (op_addr),
      .op_data   (op_data),
      .op_count  (op_count)
   );

   scratch_execute #(.ADDR_W(ADDR_W)) u_execute (
      .clk       (clk),
      .rst_n     (rst_n),
      .op_valid  (op_valid),
      .op_ready  (op_ready),
      .op_code   (op_code),
      .op_tag    (op_tag),
      .op_addr   (op_addr),
      .op_data   (op_data),
      .op_count  (op_count),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res_code  (res_code),
      .res_tag   (res_tag),
      .res_addr  (res_addr),
      .res_data  (res_data)
   );

   cpl_result u_result (
      .clk       (clk),
      .rst_n     (rst_n),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res_code  (res_code),
      .res_tag   (res_tag),
      .res_addr  (res_addr),
      .res_data  (res_data),
      .cpl_valid (cpl_valid),
      .cpl_ready (cpl_ready),
      .cpl_data  (cpl_data)
   );

endmodule

`default_nettype wire

/* dv/afu_port_tb.sv */
// AFU port testbench
// Sends host requests through the freeze bridge and compares every
// completion with a scratch memory reference model

`default_nettype none

module afu_port_tb;

   localparam int PL_DEPTH    = 2;
   localparam int FREEZE_DIS  = 0;
   localparam int ADDR_W      = 4;
   localparam int CLK_PER     = 20;
   localparam int N_DIRECTED  = 20;
   localparam int N_RAND      = 200;
   // Eight completions under random stalls fit well inside this
   localparam int CYC_PER_REQ = 80;
   localparam longint WATCHDOG_T =
      longint'((N_DIRECTED + N_RAND) * CYC_PER_REQ + 200) * CLK_PER;

   logic        clk;
   logic        rst_n;
   logic        pr_freeze;
   logic        rx_tvalid;
   logic        rx_tready;
   logic [63:0] rx_tdata;
   logic        tx_tvalid;
   logic        tx_tready;
   logic [63:0] tx_tdata;

   // Reference model state
   logic [31:0] model_mem [2**ADDR_W];
   logic [63:0] exp_q [$];
   logic [63:0] exp_head;
   int          exp_cnt;
   logic [7:0]  next_tag;
   // 0 always ready, 1 random stalls, 2 held low
   int          bp_mode;
   logic        tx_fire;

   afu_port_top #(
      .PL_DEPTH   (PL_DEPTH),
      .FREEZE_DIS (FREEZE_DIS),
      .ADDR_W     (ADDR_W)
   ) DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .pr_freeze (pr_freeze),
      .rx_tvalid (rx_tvalid),
      .rx_tready (rx_tready),
      .rx_tdata  (rx_tdata),
      .tx_tvalid (tx_tvalid),
      .tx_tready (tx_tready),
      .tx_tdata  (tx_tdata)
   );

   initial clk = 1'b0;
   always #(CLK_PER / 2) clk = ~clk;

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   function automatic void refresh_head();
      exp_cnt  = exp_q.size();
      exp_head = (exp_cnt != 0) ? exp_q[0] : 64'h0;
   endfunction

   // Count field overlaps write reserved bits, data overlaps read reserved bits
   function automatic logic [63:0] make_req(input logic [3:0] op, input logic [7:0] addr,
                                            input logic [2:0] cnt, input logic [31:0] data);
      next_tag = next_tag + 8'd1;
      return {op, next_tag, addr, cnt, 9'h0, data};
   endfunction

   // ---------------------------------------------------------------------
   // Reference model
   // ---------------------------------------------------------------------
   task automatic model_req(input logic [63:0] w);
      logic [3:0]  op;
      logic [7:0]  tag;
      logic [7:0]  addr;
      logic [7:0]  a;
      logic [2:0]  cnt;
      logic [31:0] data;
      logic [31:0] old;
      int          k;
      op   = w[63:60];
      tag  = w[59:52];
      addr = w[51:44];
      cnt  = w[43:41];
      data = w[31:0];
      case (op)
         4'h1: model_mem[addr[ADDR_W-1:0]] = data;
         4'h2: begin
            for (k = 0; k <= int'(cnt); k++) begin
               a = addr + 8'(k);
               exp_q.push_back({4'h8, tag, a, 12'h0, model_mem[a[ADDR_W-1:0]]});
            end
         end
         4'h3: begin
            old = model_mem[addr[ADDR_W-1:0]];
            model_mem[addr[ADDR_W-1:0]] = old + data;
            exp_q.push_back({4'h8, tag, addr, 12'h0, old});
         end
         default: exp_q.push_back({4'hf, tag, addr, 12'h0, 32'h0});
      endcase
      refresh_head();
   endtask

   // ---------------------------------------------------------------------
   // Stimulus helpers, entered and left 2 units after a rising edge
   // ---------------------------------------------------------------------
   task automatic send_req(input logic [63:0] w);
      logic accepted;
      model_req(w);
      rx_tvalid = 1'b1;
      rx_tdata  = w;
      do begin
         @(negedge clk);
         accepted = rx_tready;
         @(posedge clk);
         #2;
      end while (!accepted);
      rx_tvalid = 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) begin
         @(posedge clk);
         #2;
      end
      // Room for a stray extra completion to show up
      idle(6);
   endtask

   // TX back-pressure
   always @(posedge clk) begin
      #2;
      case (bp_mode)
         0:       tx_tready = 1'b1;
         1:       tx_tready = ($urandom % 4) != 0;
         default: tx_tready = 1'b0;
      endcase
   end

   // Pop after the edge so the assertions see a steady queue head
   always @(negedge clk) tx_fire = tx_tvalid && tx_tready;

   always @(posedge clk) begin
      #1;
      if (rst_n && tx_fire && exp_q.size() != 0) begin
         void'(exp_q.pop_front());
         refresh_head();
      end
   end

   // ---------------------------------------------------------------------
   // Checks
   // ---------------------------------------------------------------------
   a_reset_idle: assert property (@(posedge clk) !rst_n |=> !tx_tvalid)
      else stop_on_error("Completion valid raised straight out of reset");

   a_tx_known: assert property (@(posedge clk) disable iff (!rst_n)
      (tx_tvalid && tx_tready) |-> (exp_cnt != 0))
      else stop_on_error("Completion arrived with no request outstanding");

   a_tx_match: assert property (@(posedge clk) disable iff (!rst_n)
      (tx_tvalid && tx_tready) |-> (tx_tdata == exp_head))
      else stop_on_error($sformatf("FAIL tx_tdata got %h expected %h",
                                   $sampled(tx_tdata), $sampled(exp_head)));

   a_tx_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
      (tx_tvalid && !tx_tready) |=> $stable(tx_tdata))
      else stop_on_error($sformatf("FAIL tx_tdata changed under back-pressure %h to %h",
                                   $past(tx_tdata), $sampled(tx_tdata)));

   a_tx_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
      (tx_tvalid && !tx_tready && !pr_freeze) |=> (tx_tvalid || pr_freeze))
      else stop_on_error("Completion valid dropped before the word was taken");

   a_freeze_gate: assert property (@(posedge clk) disable iff (!rst_n)
      pr_freeze |-> (!rx_tready && !tx_tvalid))
      else stop_on_error("Stream handshake stayed open while frozen");

   initial begin
      #(WATCHDOG_T);
      stop_on_error("Completions stopped arriving before all requests finished");
   end

   // ---------------------------------------------------------------------
   // Test sequence
   // ---------------------------------------------------------------------
   initial begin
      logic [3:0] op;
      int         pick;
      int         n;
      void'($urandom(32'hae87));
      rst_n     = 1'b0;
      pr_freeze = 1'b0;
      rx_tvalid = 1'b0;
      rx_tdata  = 64'h0;
      tx_tready = 1'b1;
      bp_mode   = 0;
      next_tag  = 8'h0;
      tx_fire   = 1'b0;
      for (n = 0; n < 2**ADDR_W; n++) begin
         model_mem[n] = 32'h0;
      end
      refresh_head();
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;

      // Unwritten word reads zero
      send_req(make_req(4'h2, 8'h05, 3'd0, 32'h0));
      wait_drain();

      // Write then burst read, then reads across the array top and address byte
      send_req(make_req(4'h1, 8'h03, 3'd0, 32'h1111_2222));
      send_req(make_req(4'h2, 8'h02, 3'd3, 32'h0));
      send_req(make_req(4'h1, 8'h0f, 3'd0, 32'ha5a5_0f0f));
      send_req(make_req(4'h1, 8'h10, 3'd0, 32'h0bad_cafe));
      send_req(make_req(4'h2, 8'h0e, 3'd3, 32'h0));
      send_req(make_req(4'h2, 8'hfe, 3'd2, 32'h0));
      wait_drain();

      // Fetch-and-add wraps modulo 2^32
      send_req(make_req(4'h3, 8'h07, 3'd0, 32'hffff_fff0));
      send_req(make_req(4'h3, 8'h07, 3'd0, 32'h0000_0020));
      send_req(make_req(4'h2, 8'h07, 3'd0, 32'h0));
      wait_drain();

      // Unsupported opcodes, then normal traffic
      send_req(make_req(4'h5, 8'h33, 3'd1, 32'hdead_beef));
      send_req(make_req(4'h8, 8'h44, 3'd0, 32'h1234_5678));
      send_req(make_req(4'h2, 8'h03, 3'd0, 32'h0));
      wait_drain();

      // Fill the TX side, freeze with traffic pending, then release
      bp_mode = 2;
      send_req(make_req(4'h2, 8'h20, 3'd3, 32'h0));
      send_req(make_req(4'h2, 8'h24, 3'd3, 32'h0));
      send_req(make_req(4'h2, 8'h28, 3'd3, 32'h0));
      pr_freeze = 1'b1;
      bp_mode   = 0;
      fork
         send_req(make_req(4'h3, 8'h07, 3'd0, 32'h0000_0005));
      join_none
      idle(20);
      pr_freeze = 1'b0;
      wait fork;
      wait_drain();

      // Random mix under random back-pressure
      bp_mode = 1;
      for (n = 0; n < N_RAND; n++) begin
         pick = $urandom % 8;
         if (pick < 3) begin
            op = 4'h1;
         end else if (pick < 5) begin
            op = 4'h2;
         end else if (pick < 7) begin
            op = 4'h3;
         end else begin
            op = 4'(4 + $urandom % 12);
         end
         send_req(make_req(op, 8'($urandom), 3'($urandom), $urandom));
         idle($urandom % 4);
      end
      wait_drain();

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
hw/afu_pkg.sv
hw/axis_pipeline.sv
hw/pr_freeze_bridge.sv
hw/req_decode.sv
hw/scratch_execute.sv
hw/cpl_result.sv
hw/afu_port_top.sv
dv/afu_port_tb.sv
